// File: Bender.yml
package:
  name: soc_mem

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/soc_mem_pkg.sv
      - logic/bus_ctrl.sv
      - logic/main_ram.sv
      - logic/mtime_counter.sv
      - logic/prog_loader.sv
      - logic/soc_mem_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/soc_mem_assert.sv
      - dv/soc_mem_tb.sv

// File: all.f
+incdir+logic
logic/soc_mem_pkg.sv
logic/bus_ctrl.sv
logic/main_ram.sv
logic/mtime_counter.sv
logic/prog_loader.sv
logic/soc_mem_top.sv
dv/soc_mem_assert.sv
dv/soc_mem_tb.sv

// File: dv/soc_mem_assert.sv
module soc_mem_assert
  import soc_mem_pkg::*;
(
  input logic    clk_i,
  input logic    rst_n,
  input logic    valid_i,
  input logic    ready_i,
  input ram_wr_t ram_wr_i,
  input logic    prog_active_i,
  input logic    core_rst_n_i
);

  int unsigned fail_cnt = 0;

  // The master drops valid in the ready cycle so ready lasts one cycle
  ready_single: assert property (@(posedge clk_i) disable iff (!rst_n)
    ready_i |=> !ready_i)
    else begin
      $error("bus ready held for two cycles");
      fail_cnt++;
    end

  // Bus writes only land in the ready cycle while loader writes are exempt
  write_with_ready: assert property (@(posedge clk_i) disable iff (!rst_n)
    (ram_wr_i.en && !prog_active_i) |-> ready_i)
    else begin
      $error("RAM write without bus ready");
      fail_cnt++;
    end

  // No requests while the core is held in reset
  core_held: assert property (@(posedge clk_i) disable iff (!rst_n)
    !core_rst_n_i |-> !valid_i)
    else begin
      $error("bus request issued while the core is held in reset");
      fail_cnt++;
    end

  ready_after_reset: assert property (@(posedge clk_i)
    !rst_n |=> !ready_i)
    else begin
      $error("bus ready high right after reset");
      fail_cnt++;
    end

endmodule

bind soc_mem_top soc_mem_assert u_assert (
  .clk_i         (clk_i),
  .rst_n         (rst_n),
  .valid_i       (bus_req_i.valid),
  .ready_i       (bus_rsp_o.ready),
  .ram_wr_i      (ram_wr),
  .prog_active_i (prog_active),
  .core_rst_n_i  (core_rst_n_o)
);

// File: dv/soc_mem_tb.sv
`include "soc_mem_cfg.svh"

module soc_mem_tb
  import soc_mem_pkg::*;
;

  localparam int BUS_TIMEOUT = 100;
  localparam int LED_TIMEOUT = 4 * `CLKS_PER_BIT;
  localparam int RAM_LAT = `RAM_DELAY + 1;
  localparam int LOAD_WORDS = 8;

  logic     clk_i = 1'b0;
  logic     rst_n;
  bus_req_t bus_req_i;
  bus_rsp_t bus_rsp_o;
  logic     uart_rx_i;
  logic     prog_led_o;
  logic     core_rst_n_o;

  data_t    lcg_state = 32'h7945_eaf7;
  longint   cycle_cnt = 0;
  longint   ready_cyc;
  data_t    ram_model [`RAM_WORDS];
  ram_idx_t idx_list [8];
  int       data_errs = 0;
  int       lat_errs = 0;
  int       bit_errs = 0;
  int       timeout_errs = 0;

  soc_mem_top uut (
    .clk_i        (clk_i),
    .rst_n        (rst_n),
    .bus_req_i    (bus_req_i),
    .bus_rsp_o    (bus_rsp_o),
    .uart_rx_i    (uart_rx_i),
    .prog_led_o   (prog_led_o),
    .core_rst_n_o (core_rst_n_o)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic data_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic addr_t ram_addr(input ram_idx_t idx);
    addr_t a;
    a = `RAM_BASE;
    a[`RAM_AW+1:2] = idx;
    return a;
  endfunction

  // Only strobed byte lanes take the new value
  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input strb_t strb);
    data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic finish_run();
    int assert_fails;
    assert_fails = uut.u_assert.fail_cnt;
    $display("Errors: data %0d, latency %0d, bit %0d, timeout %0d, assertion %0d",
             data_errs, lat_errs, bit_errs, timeout_errs, assert_fails);
    if (data_errs + lat_errs + bit_errs + timeout_errs + assert_fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      lat_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      bit_errs++;
    end
  endtask

  // Ready is sampled mid-cycle and cycles count from the first cycle valid is high
  task automatic bus_xfer(input addr_t addr, input data_t wdata, input strb_t strb,
                          output data_t rdata, output int cycles);
    bus_req_t req;
    req.valid = 1'b1;
    req.addr  = addr;
    req.wdata = wdata;
    req.wstrb = strb;
    @(posedge clk_i);
    bus_req_i <= req;
    cycles = 0;
    @(negedge clk_i);
    while (!bus_rsp_o.ready && cycles < BUS_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (bus_rsp_o.ready) begin
      rdata = bus_rsp_o.rdata;
    end else begin
      $display("Bus request to address %h got no ready within %0d cycles", addr, BUS_TIMEOUT);
      timeout_errs++;
      rdata = '0;
    end
    ready_cyc = cycle_cnt;
    @(posedge clk_i);
    bus_req_i <= '0;
  endtask

  task automatic bus_read(input addr_t addr, output data_t rdata, output int cycles);
    bus_xfer(addr, '0, '0, rdata, cycles);
  endtask

  task automatic bus_write(input addr_t addr, input data_t wdata, input strb_t strb,
                           output int cycles);
    data_t unused;
    bus_xfer(addr, wdata, strb, unused, cycles);
  endtask

  // 8N1 frame sent least significant bit first
  task automatic uart_send_byte(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk_i);
      uart_rx_i <= frame[i];
      repeat (`CLKS_PER_BIT - 1) @(posedge clk_i);
    end
  endtask

  task automatic uart_send_word(input data_t w);
    for (int i = 0; i < 4; i++) begin
      uart_send_byte(w[8*i +: 8]);
    end
  endtask

  task automatic wait_prog_led(input logic level);
    int n;
    n = 0;
    @(negedge clk_i);
    while (prog_led_o !== level && n < LED_TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (prog_led_o !== level) begin
      $display("prog_led_o did not go to %b within %0d cycles", level, LED_TIMEOUT);
      timeout_errs++;
    end
  endtask

  task automatic reset_values();
    @(negedge clk_i);
    check_bit("bus_rsp_o.ready", bus_rsp_o.ready, 1'b0);
    check_bit("prog_led_o", prog_led_o, 1'b0);
    check_bit("prog_active", uut.prog_active, 1'b0);
    check_bit("core_rst_n_o", core_rst_n_o, 1'b1);
  endtask

  task automatic ram_rw();
    data_t wdata;
    data_t rd;
    data_t r;
    strb_t strb;
    int    lat;
    // Full words first so every lane of the model is known
    for (int i = 0; i < 8; i++) begin
      r = lcg_next();
      idx_list[i] = r[31:32-`RAM_AW];
      wdata = lcg_next();
      bus_write(ram_addr(idx_list[i]), wdata, 4'hF, lat);
      check_latency("ram write latency", lat, RAM_LAT);
      ram_model[idx_list[i]] = wdata;
    end
    for (int i = 0; i < 8; i++) begin
      wdata = lcg_next();
      r = lcg_next();
      strb = (r[31:28] == 4'h0) ? 4'h5 : r[31:28];
      bus_write(ram_addr(idx_list[i]), wdata, strb, lat);
      check_latency("ram strobed write latency", lat, RAM_LAT);
      ram_model[idx_list[i]] = merge_bytes(ram_model[idx_list[i]], wdata, strb);
    end
    for (int i = 0; i < 8; i++) begin
      bus_read(ram_addr(idx_list[i]), rd, lat);
      check_latency("ram read latency", lat, RAM_LAT);
      check_data("bus_rsp_o.rdata", rd, ram_model[idx_list[i]]);
    end
  endtask

  task automatic timer_reads();
    data_t  rd;
    data_t  t1;
    data_t  t2;
    longint c1;
    int     lat;
    bus_read(`MTIME_HI_ADDR, rd, lat);
    check_latency("mtime_hi latency", lat, 0);
    check_data("mtime_hi", rd, 32'h0);
    bus_read(`MTIME_LO_ADDR, t1, lat);
    c1 = ready_cyc;
    check_latency("mtime_lo latency", lat, 0);
    bus_read(`MTIME_LO_ADDR, t2, lat);
    check_latency("mtime_lo latency", lat, 0);
    check_bit("mtime_lo increasing", t2 > t1, 1'b1);
    check_bit("mtime_lo step", longint'(t2 - t1) >= (ready_cyc - c1), 1'b1);
  endtask

  task automatic unmapped_access();
    data_t rd;
    int    lat;
    bus_read(32'h1000_0000, rd, lat);
    check_latency("unmapped read latency", lat, 0);
    check_data("unmapped rdata", rd, 32'h0);
    // Just above the RAM window so a loose decode would alias word idx_list[0]
    bus_write(ram_addr(idx_list[0]) + 32'h0010_0000, lcg_next(), 4'hF, lat);
    check_latency("unmapped write latency", lat, 0);
    bus_write(32'h2000_0000 + {idx_list[1], 2'b00}, lcg_next(), 4'hF, lat);
    check_latency("unmapped write latency", lat, 0);
    for (int i = 0; i < 2; i++) begin
      bus_read(ram_addr(idx_list[i]), rd, lat);
      check_data("ram word after unmapped write", rd, ram_model[idx_list[i]]);
    end
  endtask

  task automatic program_load();
    data_t key;
    data_t w;
    key = `PROG_KEY;
    uart_send_byte(8'h11);
    uart_send_byte(8'h50);
    uart_send_byte(8'h52);
    uart_send_byte(8'h4F);
    uart_send_byte(8'h00);
    for (int i = 3; i >= 0; i--) begin
      uart_send_byte(key[8*i +: 8]);
    end
    wait_prog_led(1'b1);
    check_bit("core_rst_n_o", core_rst_n_o, 1'b0);
    uart_send_byte(8'(LOAD_WORDS));
    uart_send_byte(8'h00);
    @(negedge clk_i);
    check_bit("prog_led_o", prog_led_o, 1'b1);
    check_bit("core_rst_n_o", core_rst_n_o, 1'b0);
    for (int i = 0; i < LOAD_WORDS; i++) begin
      w = lcg_next();
      uart_send_word(w);
      ram_model[i] = w;
    end
    wait_prog_led(1'b0);
    check_bit("core_rst_n_o", core_rst_n_o, 1'b1);
  endtask

  task automatic timer_after_load();
    data_t t;
    int    lat;
    bus_read(`MTIME_LO_ADDR, t, lat);
    check_latency("mtime_lo latency", lat, 0);
    check_bit("mtime_lo below 64", t < 64, 1'b1);
  endtask

  task automatic load_readback();
    data_t rd;
    int    lat;
    for (int i = 0; i < LOAD_WORDS; i++) begin
      bus_read(ram_addr(ram_idx_t'(i)), rd, lat);
      check_latency("ram read latency", lat, RAM_LAT);
      check_data("loaded word", rd, ram_model[i]);
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    bus_req_i = '0;
    uart_rx_i = 1'b1;
    repeat (5) @(posedge clk_i);
    rst_n <= 1'b1;
    reset_values();
    ram_rw();
    timer_reads();
    unmapped_access();
    program_load();
    timer_after_load();
    load_readback();
    finish_run();
  end

endmodule

// File: logic/bus_ctrl.sv
`include "soc_mem_cfg.svh"

module bus_ctrl
  import soc_mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,
  input  logic     prog_active_i,
  input  ram_wr_t  loader_wr_i,
  output logic     ram_rd_en_o,
  output ram_idx_t ram_rd_idx_o,
  input  data_t    ram_rd_data_i,
  output ram_wr_t  ram_wr_o,
  input  mtime_t   mtime_i
);

  localparam int unsigned WAIT_W = $clog2(`RAM_DELAY);
  localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(`RAM_DELAY - 1);

  bus_state_e        state_q;
  bus_state_e        state_d;
  logic [WAIT_W-1:0] wait_cnt_q;
  logic              ram_hit;
  logic              mtime_lo_hit;
  logic              mtime_hi_hit;
  logic              is_read;
  logic              imm_ready;
  ram_wr_t           bus_wr;

  // Address decode
  assign ram_hit      = (bus_req_i.addr & ~`RAM_MASK) == `RAM_BASE;
  assign mtime_lo_hit = bus_req_i.addr == `MTIME_LO_ADDR;
  assign mtime_hi_hit = bus_req_i.addr == `MTIME_HI_ADDR;
  assign is_read      = ~|bus_req_i.wstrb;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (bus_req_i.valid && ram_hit) begin
          state_d = RAM_WAIT;
        end
      end
      RAM_WAIT: begin
        if (wait_cnt_q == WAIT_LAST) begin
          state_d = RAM_DONE;
        end
      end
      RAM_DONE: state_d = IDLE;
      default:  state_d = IDLE;
    endcase
    // Loader owns the memory, drop whatever was in flight
    if (prog_active_i) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      wait_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == RAM_WAIT) begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end else begin
        wait_cnt_q <= '0;
      end
    end
  end

  // Timer and unmapped addresses answer in the request cycle
  assign imm_ready       = bus_req_i.valid & ~ram_hit & (state_q == IDLE);
  assign bus_rsp_o.ready = ~prog_active_i & (imm_ready | (state_q == RAM_DONE));

  always_comb begin
    if (state_q == RAM_DONE) begin
      bus_rsp_o.rdata = ram_rd_data_i;
    end else if (mtime_lo_hit) begin
      bus_rsp_o.rdata = mtime_i[31:0];
    end else if (mtime_hi_hit) begin
      bus_rsp_o.rdata = mtime_i[63:32];
    end else begin
      bus_rsp_o.rdata = '0;
    end
  end

  // Read issued in the last wait stage so the word is there with ready
  assign ram_rd_en_o  = (state_q == RAM_WAIT) && (wait_cnt_q == WAIT_LAST) && is_read;
  assign ram_rd_idx_o = bus_req_i.addr[`RAM_AW+1:2];

  assign bus_wr.en   = (state_q == RAM_DONE) && !is_read;
  assign bus_wr.idx  = bus_req_i.addr[`RAM_AW+1:2];
  assign bus_wr.data = bus_req_i.wdata;
  assign bus_wr.strb = bus_req_i.wstrb;

  assign ram_wr_o = prog_active_i ? loader_wr_i : bus_wr;

endmodule

// File: logic/main_ram.sv
`include "soc_mem_cfg.svh"

module main_ram
  import soc_mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rd_en_i,
  input  ram_idx_t rd_idx_i,
  output data_t    rd_data_o,
  input  ram_wr_t  wr_i
);

  data_t mem_q [`RAM_WORDS];

  // Byte lanes are written independently
  always_ff @(posedge clk_i) begin
    if (wr_i.en) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_i.strb[b]) begin
          mem_q[wr_i.idx][8*b +: 8] <= wr_i.data[8*b +: 8];
        end
      end
    end
  end

  // Registered read port
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_idx_i];
    end
  end

endmodule

// File: logic/mtime_counter.sv
module mtime_counter
  import soc_mem_pkg::*;
(
  input  logic   clk_i,
  input  logic   core_rst_n_i,
  output mtime_t mtime_o
);

  mtime_t count_q;

  // Held at zero for as long as the core is in reset
  always_ff @(posedge clk_i) begin
    if (!core_rst_n_i) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 64'd1;
    end
  end

  assign mtime_o = count_q;

endmodule

// File: logic/prog_loader.sv
`include "soc_mem_cfg.svh"

module prog_loader
  import soc_mem_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n,
  input  logic    uart_rx_i,
  output logic    prog_active_o,
  output logic    prog_led_o,
  output ram_wr_t loader_wr_o
);

  localparam int unsigned CNT_W = $clog2(2 * `CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] FIRST_SAMPLE = CNT_W'(`CLKS_PER_BIT + `CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] BIT_RELOAD = CNT_W'(`CLKS_PER_BIT - 1);

  logic [1:0]       rx_sync_q;
  logic             rx_line;
  logic             rx_busy_q;
  logic [CNT_W-1:0] rx_cnt_q;
  logic [3:0]       rx_bit_q;
  byte_t            rx_shift_q;
  logic             rx_valid_q;

  load_state_e state_q;
  data_t       key_win_q;
  data_t       key_next;
  logic [15:0] n_words_q;
  logic [15:0] word_cnt_q;
  logic [1:0]  byte_cnt_q;
  data_t       word_buf_q;
  data_t       word_next;
  logic        wr_en_q;
  ram_idx_t    wr_idx_q;
  data_t       wr_data_q;

  assign rx_line = rx_sync_q[1];

  // Byte receiver, samples each bit in its middle
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_sync_q  <= 2'b11;
      rx_busy_q  <= 1'b0;
      rx_cnt_q   <= '0;
      rx_bit_q   <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_sync_q  <= {rx_sync_q[0], uart_rx_i};
      rx_valid_q <= 1'b0;
      if (!rx_busy_q) begin
        if (!rx_line) begin
          rx_busy_q <= 1'b1;
          rx_cnt_q  <= FIRST_SAMPLE;
          rx_bit_q  <= '0;
        end
      end else if (rx_cnt_q != '0) begin
        rx_cnt_q <= rx_cnt_q - 1'b1;
      end else if (rx_bit_q != 4'd8) begin
        rx_shift_q <= {rx_line, rx_shift_q[7:1]};
        rx_bit_q   <= rx_bit_q + 1'b1;
        rx_cnt_q   <= BIT_RELOAD;
      end else begin
        // Stop bit sample, a low line here is a framing error
        rx_busy_q  <= 1'b0;
        rx_valid_q <= rx_line;
      end
    end
  end

  assign key_next  = {key_win_q[23:0], rx_shift_q};
  assign word_next = {rx_shift_q, word_buf_q[31:8]};

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q    <= HUNT;
      key_win_q  <= '0;
      n_words_q  <= '0;
      word_cnt_q <= '0;
      byte_cnt_q <= '0;
      wr_en_q    <= 1'b0;
    end else begin
      wr_en_q <= 1'b0;
      unique case (state_q)
        HUNT: begin
          if (rx_valid_q) begin
            key_win_q <= key_next;
            if (key_next == `PROG_KEY) begin
              key_win_q  <= '0;
              byte_cnt_q <= '0;
              state_q    <= COUNT;
            end
          end
        end
        COUNT: begin
          if (rx_valid_q) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (byte_cnt_q == 2'd0) begin
              n_words_q[7:0] <= rx_shift_q;
            end else begin
              n_words_q[15:8] <= rx_shift_q;
              byte_cnt_q      <= '0;
              word_cnt_q      <= '0;
              state_q <= ({rx_shift_q, n_words_q[7:0]} == 16'd0) ? RELEASE : DATA;
            end
          end
        end
        DATA: begin
          if (rx_valid_q) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (byte_cnt_q == 2'd3) begin
              wr_en_q    <= 1'b1;
              word_cnt_q <= word_cnt_q + 16'd1;
              if (word_cnt_q + 16'd1 == n_words_q) begin
                state_q <= RELEASE;
              end
            end
          end
        end
        RELEASE: state_q <= HUNT;
        default: state_q <= HUNT;
      endcase
    end
  end

  // Word assembly, low byte arrives first
  always_ff @(posedge clk_i) begin
    if (state_q == DATA && rx_valid_q) begin
      word_buf_q <= word_next;
      if (byte_cnt_q == 2'd3) begin
        wr_idx_q  <= word_cnt_q[`RAM_AW-1:0];
        wr_data_q <= word_next;
      end
    end
  end

  assign loader_wr_o.en   = wr_en_q;
  assign loader_wr_o.idx  = wr_idx_q;
  assign loader_wr_o.data = wr_data_q;
  assign loader_wr_o.strb = 4'hF;

  assign prog_active_o = state_q != HUNT;
  assign prog_led_o    = prog_active_o;

endmodule

// File: logic/soc_mem_cfg.svh
`ifndef SOC_MEM_CFG_SVH
`define SOC_MEM_CFG_SVH

// Main memory window, decoded as (addr & ~mask) == base
`define RAM_BASE 32'h4000_0000
`define RAM_MASK 32'h000F_FFFF

// Physical RAM depth in 32-bit words
`define RAM_WORDS 1024
`define RAM_AW 10

// Emulated external RAM wait, in stages
`define RAM_DELAY 16

// Machine timer, read as two words
`define MTIME_LO_ADDR 32'h3000_0000
`define MTIME_HI_ADDR 32'h3000_0004

// UART receive bit time in clocks
`define CLKS_PER_BIT 16

// Loader keyword "PROG", first byte ends up in the top byte
`define PROG_KEY 32'h5052_4F47

`endif

// File: logic/soc_mem_pkg.sv
`include "soc_mem_cfg.svh"

package soc_mem_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] strb_t;
  typedef logic [7:0] byte_t;
  typedef logic [63:0] mtime_t;
  typedef logic [`RAM_AW-1:0] ram_idx_t;

  // All-zero wstrb is a read
  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
  } bus_req_t;

  typedef struct packed {
    logic  ready;
    data_t rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic     en;
    ram_idx_t idx;
    data_t    data;
    strb_t    strb;
  } ram_wr_t;

  typedef enum logic [1:0] {IDLE, RAM_WAIT, RAM_DONE} bus_state_e;

  typedef enum logic [1:0] {HUNT, COUNT, DATA, RELEASE} load_state_e;

endpackage

// File: logic/soc_mem_top.sv
module soc_mem_top
  import soc_mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,
  input  logic     uart_rx_i,
  output logic     prog_led_o,
  output logic     core_rst_n_o
);

  logic     prog_active;
  ram_wr_t  loader_wr;
  ram_wr_t  ram_wr;
  logic     ram_rd_en;
  ram_idx_t ram_rd_idx;
  data_t    ram_rd_data;
  mtime_t   mtime;

  // Core stays in reset while a program is being loaded
  assign core_rst_n_o = rst_n & ~prog_active;

  bus_ctrl u_bus_ctrl (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .bus_req_i     (bus_req_i),
    .bus_rsp_o     (bus_rsp_o),
    .prog_active_i (prog_active),
    .loader_wr_i   (loader_wr),
    .ram_rd_en_o   (ram_rd_en),
    .ram_rd_idx_o  (ram_rd_idx),
    .ram_rd_data_i (ram_rd_data),
    .ram_wr_o      (ram_wr),
    .mtime_i       (mtime)
  );

  main_ram u_main_ram (
    .clk_i     (clk_i),
    .rd_en_i   (ram_rd_en),
    .rd_idx_i  (ram_rd_idx),
    .rd_data_o (ram_rd_data),
    .wr_i      (ram_wr)
  );

  mtime_counter u_mtime_counter (
    .clk_i        (clk_i),
    .core_rst_n_i (core_rst_n_o),
    .mtime_o      (mtime)
  );

  prog_loader u_prog_loader (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .uart_rx_i     (uart_rx_i),
    .prog_active_o (prog_active),
    .prog_led_o    (prog_led_o),
    .loader_wr_o   (loader_wr)
  );

endmodule
